// ==== common/vic_pkg.sv ====
`default_nettype none

package vic_pkg;

   // chip model, 0 = ntsc, 1 = pal
   typedef enum logic [0:0] {
      CHIP_NTSC = 1'b0,
      CHIP_PAL  = 1'b1
   } chip_t;

   // opcodes on the mcu config link
   typedef enum logic [7:0] {
      OP_READ_REG  = 8'h01, // opcode, addr -> value
      OP_WRITE_REG = 8'h02, // opcode, addr, data -> no reply
      OP_GET_CHIP  = 8'h03  // opcode -> chip code
   } mcu_op_t;

   typedef enum logic [2:0] {
      ST_OPCODE,
      ST_ADDR,
      ST_DATA,
      ST_ACCESS,
      ST_REPLY
   } parse_state_t;

   // register map
   localparam logic [5:0] REG_CTRL       = 6'h11; // bit 7 is raster msb
   localparam logic [5:0] REG_RASTER     = 6'h12;
   localparam logic [5:0] REG_IRQ_STATUS = 6'h19;
   localparam logic [5:0] REG_IRQ_ENABLE = 6'h1A;
   localparam logic [5:0] REG_LAST       = 6'h2E; // above this reads 0xff

   // raster geometry in bus cycles per line, lines per frame
   localparam logic [6:0] NTSC_CYCLES = 7'd65;
   localparam logic [8:0] NTSC_LINES  = 9'd263;
   localparam logic [6:0] PAL_CYCLES  = 7'd63;
   localparam logic [8:0] PAL_LINES   = 9'd312;

   // sync widths
   localparam logic [6:0] HSYNC_CYCLES = 7'd4;
   localparam logic [8:0] VSYNC_LINES  = 9'd3;

endpackage : vic_pkg

`default_nettype wire

// ==== rtl/raster_timer.sv ====
`default_nettype none

module raster_timer
   import vic_pkg::*;
#(
   parameter int CLKS_PER_CYCLE = 8
) (
   input  wire         sys_clock,
   input  wire         rst_n,
   input  wire chip_t  chip,
   output logic        hsync,
   output logic        vsync,
   output logic [8:0]  raster,
   output logic        line_start
);

   localparam int PW = (CLKS_PER_CYCLE > 1) ? $clog2(CLKS_PER_CYCLE) : 1;
   localparam logic [PW-1:0] PRE_MAX = PW'(CLKS_PER_CYCLE - 1);

   logic [PW-1:0] presc;
   logic [6:0]    cycle;
   chip_t         chip_q;      // model used for the current frame
   logic          tick;        // last sys_clock of a raster cycle
   logic          end_of_line;
   logic          end_of_frame;
   logic [6:0]    cycle_nxt;
   logic [8:0]    line_nxt;
   logic [6:0]    cycles_max;
   logic [8:0]    lines_max;

   assign cycles_max = (chip_q == CHIP_PAL) ? PAL_CYCLES : NTSC_CYCLES;
   assign lines_max  = (chip_q == CHIP_PAL) ? PAL_LINES : NTSC_LINES;

   assign tick         = (presc == PRE_MAX);
   assign end_of_line  = (cycle == cycles_max - 7'd1);
   assign end_of_frame = end_of_line && (raster == lines_max - 9'd1);

   // position after the coming tick
   assign cycle_nxt = end_of_line ? 7'd0 : cycle + 7'd1;
   assign line_nxt  = end_of_frame ? 9'd0 : (end_of_line ? raster + 9'd1 : raster);

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         presc      <= '0;
         cycle      <= '0;
         raster     <= '0;
         chip_q     <= CHIP_NTSC;
         hsync      <= 1'b0;
         vsync      <= 1'b0;
         line_start <= 1'b0;
      end else begin
         line_start <= tick && end_of_line; // one sys_clock wide
         if (tick) begin
            presc  <= '0;
            cycle  <= cycle_nxt;
            raster <= line_nxt;  // new line number lands with line_start
            hsync  <= (cycle_nxt < HSYNC_CYCLES);
            vsync  <= (line_nxt < VSYNC_LINES);
            // sample the model on the first cycle of line 0
            if (cycle == 7'd0 && raster == 9'd0)
               chip_q <= chip;
         end else begin
            presc <= presc + 1'b1;
         end
      end
   end

endmodule : raster_timer

`default_nettype wire

// ==== rtl/reg_arbiter.sv ====
`default_nettype none

module reg_arbiter (
   input  wire        sys_clock,
   input  wire        rst_n,
   // cpu bus
   input  wire        ce,          // active low
   input  wire        rw,          // high = read
   input  wire  [5:0] addr,
   input  wire  [7:0] data_in,
   output logic [7:0] data_out,
   output logic       data_valid,
   // mcu side, held until mcu_done
   input  wire        mcu_req,
   input  wire        mcu_we,
   input  wire  [5:0] mcu_addr,
   input  wire  [7:0] mcu_wdata,
   output logic       mcu_done,
   output logic [7:0] mcu_rdata,
   // shared register port
   output logic       reg_en,
   output logic       reg_we,
   output logic [5:0] reg_addr,
   output logic [7:0] reg_wdata,
   input  wire  [7:0] reg_rdata
);

   logic cpu_act;    // cpu owns the port this cycle
   logic mcu_grant;
   logic cpu_rd_q;   // cpu read issued last cycle
   logic mcu_own_q;  // mcu access issued last cycle

   assign cpu_act = ~ce;
   // mcu only gets idle cycles, and not again while its done is pending
   assign mcu_grant = ce && mcu_req && !mcu_own_q;

   assign reg_en    = cpu_act | mcu_grant;
   assign reg_we    = cpu_act ? ~rw : mcu_we;
   assign reg_addr  = cpu_act ? addr : mcu_addr;
   assign reg_wdata = cpu_act ? data_in : mcu_wdata;

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         cpu_rd_q  <= 1'b0;
         mcu_own_q <= 1'b0;
      end else begin
         cpu_rd_q  <= cpu_act && rw; // writes give no valid
         mcu_own_q <= mcu_grant;     // reads and writes both get done
      end
   end

   // read data returns one cycle after the grant, steered by owner
   assign data_out   = cpu_rd_q ? reg_rdata : 8'h00;
   assign data_valid = cpu_rd_q;
   assign mcu_rdata  = mcu_own_q ? reg_rdata : 8'h00;
   assign mcu_done   = mcu_own_q;

endmodule : reg_arbiter

`default_nettype wire

// ==== rtl/vic_regs.sv ====
`default_nettype none

module vic_regs
   import vic_pkg::*;
(
   input  wire        sys_clock,
   input  wire        rst_n,
   input  wire        reg_en,
   input  wire        reg_we,
   input  wire  [5:0] reg_addr,
   input  wire  [7:0] reg_wdata,
   output logic [7:0] reg_rdata,
   input  wire  [8:0] raster,
   input  wire        line_start,
   output logic       irq
);

   logic [7:0] mem [0:REG_LAST]; // plain byte storage
   logic [8:0] cmp;              // raster compare line
   logic [3:0] flags;            // irq status, bit 0 is raster
   logic [7:0] irq_en;
   logic       wr;
   logic       rst_hit;          // raster reached compare
   logic [7:0] rd_val;

   assign wr      = reg_en && reg_we;
   assign rst_hit = line_start && (raster == cmp);
   assign irq     = |(flags & irq_en[3:0]);

   always_ff @(posedge sys_clock) begin
      if (wr && reg_addr <= REG_LAST)
         mem[reg_addr] <= reg_wdata;
   end

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         cmp    <= '0;
         flags  <= '0;
         irq_en <= '0;
      end else begin
         if (wr && reg_addr == REG_RASTER)
            cmp[7:0] <= reg_wdata;
         if (wr && reg_addr == REG_CTRL)
            cmp[8] <= reg_wdata[7];
         if (wr && reg_addr == REG_IRQ_ENABLE)
            irq_en <= reg_wdata;
         // write 1 to clear, a new hit wins over the clear
         if (wr && reg_addr == REG_IRQ_STATUS)
            flags <= (flags & ~reg_wdata[3:0]) | {3'b000, rst_hit};
         else
            flags <= flags | {3'b000, rst_hit};
      end
   end

   always_comb begin
      if (reg_addr > REG_LAST)
         rd_val = 8'hFF; // unused
      else if (reg_addr == REG_RASTER)
         rd_val = raster[7:0];
      else if (reg_addr == REG_CTRL)
         rd_val = {raster[8], mem[REG_CTRL][6:0]};
      else if (reg_addr == REG_IRQ_STATUS)
         rd_val = {irq, 3'b111, flags};
      else if (reg_addr == REG_IRQ_ENABLE)
         rd_val = irq_en;
      else
         rd_val = mem[reg_addr];
   end

   always_ff @(posedge sys_clock) begin
      if (reg_en && !reg_we)
         reg_rdata <= rd_val; // valid the cycle after the access
   end

endmodule : vic_regs

`default_nettype wire

// ==== mcu_link/mcu_cmd_parser.sv ====
`default_nettype none

module mcu_cmd_parser
   import vic_pkg::*;
(
   input  wire         sys_clock,
   input  wire         rst_n,
   input  wire chip_t  chip,
   input  wire  [7:0]  rx_data,
   input  wire         rx_valid,
   output logic        link_busy,
   // register access through the arbiter
   output logic        mcu_req,
   output logic        mcu_we,
   output logic [5:0]  mcu_addr,
   output logic [7:0]  mcu_wdata,
   input  wire         mcu_done,
   input  wire  [7:0]  mcu_rdata,
   // response bytes toward the tx fifo
   output logic [7:0]  resp_data,
   output logic        resp_push,
   input  wire         resp_full
);

   parse_state_t state;
   mcu_op_t      op;       // opcode of the command in flight
   logic [7:0]   resp_q;   // reply byte waiting for room

   // busy while executing or replying, or when the fifo has no room
   assign link_busy = (state == ST_ACCESS) || (state == ST_REPLY) || resp_full;

   assign mcu_req   = (state == ST_ACCESS);
   assign mcu_we    = (op == OP_WRITE_REG);
   assign resp_push = (state == ST_REPLY) && !resp_full;
   assign resp_data = resp_q;

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_OPCODE;
         op    <= OP_READ_REG;
      end else begin
         case (state)
            ST_OPCODE:
               if (rx_valid) begin
                  case (mcu_op_t'(rx_data))
                     OP_READ_REG, OP_WRITE_REG: begin
                        op    <= mcu_op_t'(rx_data);
                        state <= ST_ADDR;
                     end
                     OP_GET_CHIP: begin
                        op    <= OP_GET_CHIP;
                        state <= ST_REPLY;
                     end
                     default: state <= ST_OPCODE; // unknown, dropped
                  endcase
               end
            ST_ADDR:
               if (rx_valid)
                  state <= (op == OP_WRITE_REG) ? ST_DATA : ST_ACCESS;
            ST_DATA:
               if (rx_valid)
                  state <= ST_ACCESS;
            ST_ACCESS:
               if (mcu_done)
                  state <= (op == OP_READ_REG) ? ST_REPLY : ST_OPCODE;
            ST_REPLY:
               if (!resp_full)
                  state <= ST_OPCODE;
            default: state <= ST_OPCODE;
         endcase
      end
   end

   // command payload
   always_ff @(posedge sys_clock) begin
      if (state == ST_ADDR && rx_valid)
         mcu_addr <= rx_data[5:0];
      if (state == ST_DATA && rx_valid)
         mcu_wdata <= rx_data;
      if (state == ST_OPCODE && rx_valid && mcu_op_t'(rx_data) == OP_GET_CHIP)
         resp_q <= {7'd0, chip}; // 0 ntsc, 1 pal
      else if (state == ST_ACCESS && mcu_done)
         resp_q <= mcu_rdata;
   end

endmodule : mcu_cmd_parser

`default_nettype wire

// ==== mcu_link/mcu_tx_credit.sv ====
`default_nettype none

module mcu_tx_credit #(
   parameter int CREDITS    = 4,
   parameter int RESP_DEPTH = 8
) (
   input  wire        sys_clock,
   input  wire        rst_n,
   input  wire  [7:0] resp_data,
   input  wire        resp_push,
   output logic       resp_full,
   output logic [7:0] tx_data,
   output logic       tx_valid,
   input  wire        credit_return
);

   localparam int AW = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
   localparam int NW = $clog2(RESP_DEPTH + 1);
   localparam int CW = $clog2(CREDITS + 1);
   localparam logic [AW-1:0] PTR_MAX    = AW'(RESP_DEPTH - 1);
   localparam logic [NW-1:0] DEPTH_N    = NW'(RESP_DEPTH);
   localparam logic [CW-1:0] CREDIT_MAX = CW'(CREDITS);

   logic [7:0]    fifo [0:RESP_DEPTH-1];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [NW-1:0] count;
   logic [CW-1:0] credits;   // free slots on the mcu side
   logic          push;
   logic          send;

   assign resp_full = (count == DEPTH_N);
   assign push      = resp_push && !resp_full;
   assign send      = (count != '0) && (credits != '0); // one byte per cycle max

   always_ff @(posedge sys_clock) begin
      if (push)
         fifo[wr_ptr] <= resp_data;
      if (send)
         tx_data <= fifo[rd_ptr];
   end

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credits  <= CREDIT_MAX;
         tx_valid <= 1'b0;
      end else begin
         tx_valid <= send;
         if (push)
            wr_ptr <= (wr_ptr == PTR_MAX) ? '0 : wr_ptr + 1'b1;
         if (send)
            rd_ptr <= (rd_ptr == PTR_MAX) ? '0 : rd_ptr + 1'b1;
         count <= count + NW'(push) - NW'(send);
         // a return and a send together leave the count alone
         if (credit_return && !send && credits != CREDIT_MAX)
            credits <= credits + 1'b1;
         else if (send && !credit_return)
            credits <= credits - 1'b1;
      end
   end

endmodule : mcu_tx_credit

`default_nettype wire

// ==== rtl/vic_top.sv ====
`default_nettype none

module vic_top
   import vic_pkg::*;
#(
   parameter int CLKS_PER_CYCLE = 8,
   parameter int CREDITS        = 4,
   parameter int RESP_DEPTH     = 8
) (
   input  wire         sys_clock,
   input  wire         rst_n,
   input  wire chip_t  chip,
   // host cpu bus
   input  wire         ce,
   input  wire         rw,
   input  wire  [5:0]  addr,
   input  wire  [7:0]  data_in,
   output logic [7:0]  data_out,
   output logic        data_valid,
   output logic        irq,
   output logic        hsync,
   output logic        vsync,
   // mcu config link
   input  wire  [7:0]  rx_data,
   input  wire         rx_valid,
   output logic        link_busy,
   output logic [7:0]  tx_data,
   output logic        tx_valid,
   input  wire         credit_return
);

   logic [8:0] raster;
   logic       line_start;
   logic       mcu_req, mcu_we, mcu_done;
   logic [5:0] mcu_addr;
   logic [7:0] mcu_wdata, mcu_rdata;
   logic       reg_en, reg_we;
   logic [5:0] reg_addr;
   logic [7:0] reg_wdata, reg_rdata;
   logic [7:0] resp_data;
   logic       resp_push, resp_full;

   raster_timer #(.CLKS_PER_CYCLE(CLKS_PER_CYCLE)) u_timer (
      .sys_clock(sys_clock), .rst_n(rst_n), .chip(chip),
      .hsync(hsync), .vsync(vsync), .raster(raster), .line_start(line_start));

   reg_arbiter u_arb (
      .sys_clock(sys_clock), .rst_n(rst_n),
      .ce(ce), .rw(rw), .addr(addr), .data_in(data_in),
      .data_out(data_out), .data_valid(data_valid),
      .mcu_req(mcu_req), .mcu_we(mcu_we), .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata),
      .mcu_done(mcu_done), .mcu_rdata(mcu_rdata),
      .reg_en(reg_en), .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
      .reg_rdata(reg_rdata));

   vic_regs u_regs (
      .sys_clock(sys_clock), .rst_n(rst_n),
      .reg_en(reg_en), .reg_we(reg_we), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
      .reg_rdata(reg_rdata), .raster(raster), .line_start(line_start), .irq(irq));

   mcu_cmd_parser u_parser (
      .sys_clock(sys_clock), .rst_n(rst_n), .chip(chip),
      .rx_data(rx_data), .rx_valid(rx_valid), .link_busy(link_busy),
      .mcu_req(mcu_req), .mcu_we(mcu_we), .mcu_addr(mcu_addr), .mcu_wdata(mcu_wdata),
      .mcu_done(mcu_done), .mcu_rdata(mcu_rdata),
      .resp_data(resp_data), .resp_push(resp_push), .resp_full(resp_full));

   mcu_tx_credit #(.CREDITS(CREDITS), .RESP_DEPTH(RESP_DEPTH)) u_tx (
      .sys_clock(sys_clock), .rst_n(rst_n),
      .resp_data(resp_data), .resp_push(resp_push), .resp_full(resp_full),
      .tx_data(tx_data), .tx_valid(tx_valid), .credit_return(credit_return));

endmodule : vic_top

`default_nettype wire

// ==== verification/tb_vic_top.sv ====
`default_nettype none

module tb_vic_top;
   import vic_pkg::*;

   localparam int CLKS_PER_CYCLE = 1;
   localparam int CREDITS        = 2;
   localparam int RESP_DEPTH     = 4;
   localparam int TIMEOUT        = 40000; // wait limit in cycles above one pal frame

   logic       sys_clock, rst_n, ce, rw, rx_valid, credit_return;
   chip_t      chip;
   logic [5:0] addr;
   logic [7:0] data_in, rx_data;
   logic [7:0] data_out, tx_data;
   logic       data_valid, irq, hsync, vsync, link_busy, tx_valid;

   logic [7:0] model_mem [0:63];   // last value written per address
   logic [7:0] cpu_exp[$];         // expected data_out per read
   int         cpu_due[$];         // cycle in which data_valid is due
   logic [7:0] tx_exp[$];          // expected tx bytes in order
   logic [7:0] last_tx;
   logic       auto_credit, manual_credit;
   int         cycle_cnt = 0;
   int         tx_count = 0;
   int         errors = 0;
   int         checks = 0;
   int         test_base = 0;
   integer     seed;

   vic_top #(.CLKS_PER_CYCLE(CLKS_PER_CYCLE), .CREDITS(CREDITS), .RESP_DEPTH(RESP_DEPTH)) UUT (
      .sys_clock(sys_clock), .rst_n(rst_n), .chip(chip),
      .ce(ce), .rw(rw), .addr(addr), .data_in(data_in),
      .data_out(data_out), .data_valid(data_valid), .irq(irq), .hsync(hsync), .vsync(vsync),
      .rx_data(rx_data), .rx_valid(rx_valid), .link_busy(link_busy),
      .tx_data(tx_data), .tx_valid(tx_valid), .credit_return(credit_return));

   initial begin
      sys_clock = 1'b0;
      forever #20 sys_clock = ~sys_clock;
   end

   always @(posedge sys_clock) begin
      cycle_cnt <= cycle_cnt + 1;
      if (tx_valid)
         tx_count <= tx_count + 1; // stable for readers on the falling edge
   end

   // expected read value from the register map rules
   function automatic logic [7:0] ref_read(input logic [5:0] a, input logic [8:0] line = 9'd0,
                                           input logic [3:0] flg = 4'd0);
      if (a > REG_LAST)
         return 8'hFF;
      else if (a == REG_RASTER)
         return line[7:0];
      else if (a == REG_CTRL)
         return {line[8], model_mem[a][6:0]};
      else if (a == REG_IRQ_STATUS)
         return {|(flg & model_mem[REG_IRQ_ENABLE][3:0]), 3'b111, flg};
      return model_mem[a]; // plain bytes and the enable register
   endfunction

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s: got 0x%02h expected 0x%02h", name, got, exp);
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_chip(input chip_t got, input chip_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] chip code: got 0x%0h expected 0x%0h", got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      checks++;
      if (got != exp) begin
         errors++;
         $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic abort_on_timeout(input string what);
      $display("timed out waiting for %s", what);
      $display("TESTBENCH FAILED");
      $finish;
   endtask

   task automatic end_test(input string name);
      $display("test %s: %s, %0d errors", name, (errors == test_base) ? "ok" : "failed",
               errors - test_base);
      test_base = errors;
   endtask

   // compare every read return and every tx byte, and hand back credits
   always @(negedge sys_clock) begin
      if (rst_n && data_valid) begin
         if (cpu_exp.size() == 0) begin
            errors++;
            $display("data_valid pulsed with no cpu read outstanding");
         end else begin
            check_byte("data_out", data_out, cpu_exp.pop_front());
            check_count("data_valid cycle", cycle_cnt, cpu_due.pop_front());
         end
      end
      if (rst_n && tx_valid) begin
         last_tx = tx_data;
         if (tx_exp.size() == 0) begin
            errors++;
            $display("tx_valid pulsed with no response expected");
         end else
            check_byte("tx_data", tx_data, tx_exp.pop_front());
      end
      credit_return = (auto_credit && tx_valid) || manual_credit;
   end

   // drives one bus cycle on the falling edge and leaves ce low until cpu_idle
   task automatic cpu_access(input logic wr, input logic [5:0] a, input logic [7:0] d,
                             input logic [8:0] line = 9'd0, input logic [3:0] flg = 4'd0);
      @(negedge sys_clock);
      ce      = 1'b0;
      rw      = ~wr;
      addr    = a;
      data_in = d;
      if (wr)
         model_mem[a] = d;
      else begin
         cpu_exp.push_back(ref_read(a, line, flg));
         cpu_due.push_back(cycle_cnt + 1);
      end
   endtask

   task automatic cpu_idle(input int n);
      @(negedge sys_clock);
      ce = 1'b1;
      repeat (n - 1) @(negedge sys_clock);
   endtask

   task automatic mcu_send(input logic [7:0] b);
      int t;
      t = 0;
      @(negedge sys_clock);
      while (link_busy) begin
         rx_valid = 1'b0;
         t = t + 1;
         if (t > TIMEOUT)
            abort_on_timeout("link_busy to drop");
         @(negedge sys_clock);
      end
      rx_valid = 1'b1;
      rx_data  = b;
   endtask

   task automatic mcu_release();
      @(negedge sys_clock);
      rx_valid = 1'b0;
   endtask

   task automatic mcu_read(input logic [5:0] a);
      mcu_send(OP_READ_REG);
      mcu_send({2'b00, a});
      tx_exp.push_back(ref_read(a));
      mcu_release();
   endtask

   task automatic mcu_write(input logic [5:0] a, input logic [7:0] d);
      model_mem[a] = d;
      mcu_send(OP_WRITE_REG);
      mcu_send({2'b00, a});
      mcu_send(d);
      mcu_release();
   endtask

   task automatic mcu_get_chip();
      mcu_send(OP_GET_CHIP);
      tx_exp.push_back({7'd0, chip}); // 0 ntsc, 1 pal
      mcu_release();
   endtask

   task automatic give_credit();
      @(posedge sys_clock);
      manual_credit = 1'b1; // copied onto credit_return at the next falling edge
      @(posedge sys_clock);
      manual_credit = 1'b0;
   endtask

   task automatic wait_drained();
      int t;
      t = 0;
      while (cpu_exp.size() != 0 || tx_exp.size() != 0) begin
         @(negedge sys_clock);
         t = t + 1;
         if (t > TIMEOUT)
            abort_on_timeout("outstanding reads and responses");
      end
      repeat (4) @(negedge sys_clock);
   endtask

   task automatic wait_tx_count(input int n);
      int t;
      t = 0;
      while (tx_count < n) begin
         @(negedge sys_clock);
         t = t + 1;
         if (t > TIMEOUT)
            abort_on_timeout("a tx byte after credit return");
      end
   endtask

   task automatic wait_irq_high();
      int t;
      t = 0;
      while (!irq) begin
         @(negedge sys_clock);
         t = t + 1;
         if (t > TIMEOUT)
            abort_on_timeout("the raster interrupt");
      end
   endtask

   // low first, then high, so a level already high is not taken as an edge
   task automatic wait_sync_rise(input logic use_vsync);
      int t;
      t = 0;
      do begin
         @(negedge sys_clock);
         t = t + 1;
         if (t > TIMEOUT)
            abort_on_timeout(use_vsync ? "vsync low" : "hsync low");
      end while (use_vsync ? vsync : hsync);
      do begin
         @(negedge sys_clock);
         t = t + 1;
         if (t > TIMEOUT)
            abort_on_timeout(use_vsync ? "vsync high" : "hsync high");
      end while (!(use_vsync ? vsync : hsync));
   endtask

   initial begin
      logic [31:0] r;
      logic [5:0]  a;
      int          base;
      int          t0;
      int          cyc;
      int          lin;
      seed          = 56;
      ce            = 1'b1;
      rw            = 1'b1;
      addr          = '0;
      data_in       = '0;
      rx_data       = '0;
      rx_valid      = 1'b0;
      credit_return = 1'b0;
      chip          = CHIP_NTSC;
      auto_credit   = 1'b1;
      manual_credit = 1'b0;
      rst_n         = 1'b0;
      repeat (5) @(negedge sys_clock);
      check_level("data_valid", data_valid, 1'b0); // outputs held low in reset
      check_level("tx_valid", tx_valid, 1'b0);
      check_level("irq", irq, 1'b0);
      check_level("link_busy", link_busy, 1'b0);
      check_level("hsync", hsync, 1'b0);
      check_level("vsync", vsync, 1'b0);
      rst_n = 1'b1;
      end_test("0 reset levels");

      for (int i = 0; i < 64; i++)
         cpu_access(1'b1, 6'(i), 8'($random(seed))); // every address gets a known byte
      for (int i = 0; i < 300; i++) begin
         r = $random(seed);
         a = r[13:8];
         if (a == REG_CTRL || a == REG_RASTER || a == REG_IRQ_STATUS)
            a = a ^ 6'h20; // raster-dependent registers go to test 2
         cpu_access(r[0], a, r[23:16]);
         if (r[4])
            cpu_idle(1 + int'(r[6:5]));
      end
      cpu_idle(1);
      wait_drained();
      end_test("1 cpu random access");

      cpu_access(1'b1, REG_RASTER, 8'd5);
      cpu_access(1'b1, REG_CTRL, 8'h00);       // compare bit 8 clear
      cpu_access(1'b1, REG_IRQ_STATUS, 8'h0F);
      cpu_access(1'b1, REG_IRQ_ENABLE, 8'h01);
      cpu_idle(1);
      wait_irq_high();
      cpu_access(1'b0, REG_RASTER, 8'h00, 9'd5);
      cpu_access(1'b0, REG_IRQ_STATUS, 8'h00, 9'd5, 4'h1);
      cpu_access(1'b1, REG_IRQ_STATUS, 8'h01); // clear the raster flag
      cpu_idle(1);
      check_level("irq", irq, 1'b0);
      wait_drained();
      end_test("2 raster interrupt");

      fork
         for (int i = 0; i < 40; i++) begin // cpu keeps to 0x00-0x0f
            r = $random(seed);
            cpu_access(r[0], 6'(r[11:8]), r[23:16]);
            cpu_idle(1 + int'(r[3:2]));
         end
         for (int j = 0; j < 20; j++) begin // mcu keeps to 0x20-0x2e
            mcu_write(6'h20 + 6'(j % 15), 8'(j * 59 + 17));
            mcu_read(6'h20 + 6'(j % 15));
         end
      join
      for (int i = 0; i < 16; i++)
         mcu_read(6'(i));
      for (int i = 32; i <= 46; i++)
         cpu_access(1'b0, 6'(i), 8'h00);
      cpu_idle(1);
      wait_drained();
      end_test("3 mcu with cpu traffic");

      auto_credit = 1'b0;
      base = tx_count;
      for (int k = 0; k < CREDITS + RESP_DEPTH; k++)
         mcu_read(6'h20 + 6'(k));
      repeat (10) @(negedge sys_clock);
      check_count("bytes without credit return", tx_count - base, CREDITS);
      check_level("link_busy", link_busy, 1'b1); // fifo full
      for (int k = 0; k < RESP_DEPTH; k++) begin
         give_credit();
         wait_tx_count(base + CREDITS + k + 1);
         repeat (8) @(negedge sys_clock);
         check_count("bytes after credit return", tx_count - base, CREDITS + k + 1);
      end
      repeat (CREDITS) give_credit();
      auto_credit = 1'b1;
      wait_drained();
      end_test("4 credit flow control");

      for (int c = 0; c < 2; c++) begin
         @(negedge sys_clock);
         chip = chip_t'(c);
         cyc  = (chip == CHIP_PAL) ? int'(PAL_CYCLES) : int'(NTSC_CYCLES);
         lin  = (chip == CHIP_PAL) ? int'(PAL_LINES) : int'(NTSC_LINES);
         wait_sync_rise(1'b1); // model is latched at this frame start
         t0 = cycle_cnt;
         wait_sync_rise(1'b1);
         check_count("vsync period", cycle_cnt - t0, lin * cyc * CLKS_PER_CYCLE);
         wait_sync_rise(1'b0);
         t0 = cycle_cnt;
         wait_sync_rise(1'b0);
         check_count("hsync period", cycle_cnt - t0, cyc * CLKS_PER_CYCLE);
         mcu_get_chip();
         wait_drained();
         check_chip(chip_t'(last_tx[0]), chip);
      end
      end_test("5 sync timing and chip code");

      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule : tb_vic_top

`default_nettype wire

// ==== src.f ====
common/vic_pkg.sv
rtl/raster_timer.sv
rtl/reg_arbiter.sv
rtl/vic_regs.sv
mcu_link/mcu_cmd_parser.sv
mcu_link/mcu_tx_credit.sv
rtl/vic_top.sv
verification/tb_vic_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_vic_top -f src.f -o tb_vic_top
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_vic_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
   echo "failure found in $LOG"
   exit 1
fi
echo "no failure found in $LOG"
exit 0
